// File: build.f
+incdir+include
logic/codecPkg.sv
logic/seqDivider.sv
logic/freqModel.sv
logic/encoderCtrl.sv
logic/bitPacker.sv
logic/arithEncoder.sv
verif/arithEncoderTb.sv

// File: include/codec_consts.svh
// Codec constants
`ifndef CODEC_CONSTS_SVH
`define CODEC_CONSTS_SVH

// interval arithmetic
`define codecPrecision 16
`define whole          16'd32768   // 2^(precision-1)
`define half           16'd16384
`define quarter        16'd8192
`define threeQuarters  16'd24576

// alphabet
`define numSymbols     257
`define eofSymbol      9'd256
`define symbolWidth    9

// frequency and product widths
`define freqWidth      13          // total stays below quarter
`define prodWidth      29          // precision plus freqWidth

// output words
`define wordWidth      32
`define wordBytes      4

`endif

// File: logic/arithEncoder.sv
// Arithmetic encoder top
`timescale 1ns/1ns
`include "codec_consts.svh"

module arithEncoder (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 start,
    input  codecPkg::symbolValue symbolIn,
    input  logic                 newBitsProvided,
    input  logic                 readSuccess,
    output logic                 idle,
    output logic                 newBitsRequested,
    output logic                 resultReady,
    output logic [2:0]           validOutputBytes,
    output logic [`wordWidth-1:0] codeWord
);

    logic                 modelClear;
    logic                 modelUpdate;
    logic                 modelReady;
    codecPkg::symbolValue curSymbol;
    codecPkg::symRange    range;
    logic                 divStart;
    logic                 divDone;
    codecPkg::divRequest  request;
    codecPkg::codeValue   quotient;
    codecPkg::emitBit     bitOut;
    logic                 packerStall;

    encoderCtrl ctrl0 (.clk, .rstn, .start, .symbolIn, .newBitsProvided, .idle,
        .newBitsRequested, .modelClear, .modelUpdate, .curSymbol, .range, .modelReady,
        .divStart, .request, .divDone, .quotient, .bitOut, .packerStall);

    freqModel model0 (.clk, .rstn, .modelClear, .curSymbol, .modelUpdate, .range,
        .modelReady);

    seqDivider divider0 (.clk, .rstn, .divStart, .request, .divDone, .quotient);

    bitPacker packer0 (.clk, .rstn, .bitIn(bitOut), .readSuccess, .packerStall,
        .resultReady, .validOutputBytes, .codeWord);

endmodule

// File: logic/bitPacker.sv
// Output word packer
`timescale 1ns/1ns
`include "codec_consts.svh"

module bitPacker (
    input  logic                        clk,
    input  logic                        rstn,
    input  codecPkg::emitBit            bitIn,
    input  logic                        readSuccess,
    output logic                        packerStall,
    output logic                        resultReady,
    output logic [$clog2(`wordBytes):0] validOutputBytes,
    output logic [`wordWidth-1:0]       codeWord
);

    logic [$clog2(`wordWidth)-1:0] bitPtr;
    logic                          wordFull;   // word presented until read completes
    logic                          ackSeen;    // readSuccess went high
    logic                          wordDone;

    assign wordDone    = bitIn.valid && (bitPtr == 5'(`wordWidth - 1) || bitIn.last);
    assign packerStall = wordFull;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            codeWord    <= '0;
            bitPtr      <= '0;
            wordFull    <= 1'b0;
            ackSeen     <= 1'b0;
            resultReady <= 1'b0;
        end else if (!wordFull) begin
            if (bitIn.valid) begin
                codeWord[bitPtr] <= bitIn.value;   // first bit lands in bit 0
                if (wordDone) begin
                    wordFull    <= 1'b1;
                    resultReady <= 1'b1;
                end else begin
                    bitPtr <= bitPtr + 1'b1;
                end
            end
        end else if (!ackSeen) begin
            if (readSuccess) begin
                resultReady <= 1'b0;
                ackSeen     <= 1'b1;
                codeWord    <= '0;
                bitPtr      <= '0;
            end
        end else if (!readSuccess) begin
            ackSeen  <= 1'b0;
            wordFull <= 1'b0;
        end
    end

    // bytes holding bits 0 to bitPtr
    always_ff @(posedge clk) begin
        if (!wordFull && wordDone) begin
            validOutputBytes <= {1'b0, bitPtr[4:3]} + 3'd1;
        end
    end

endmodule

// File: logic/codecPkg.sv
// Codec shared types
`include "codec_consts.svh"

package codecPkg;

    typedef logic [`codecPrecision-1:0] codeValue;   // interval bound or width
    typedef logic [`freqWidth-1:0]      freqValue;
    typedef logic [`symbolWidth-1:0]    symbolValue;

    // model answer for one symbol
    typedef struct packed {
        freqValue freqBegin;
        freqValue freqEnd;
        freqValue total;
    } symRange;

    typedef struct packed {
        logic [`prodWidth-1:0] dividend;
        freqValue              divisor;
    } divRequest;

    // one code bit from the controller
    typedef struct packed {
        logic valid;
        logic value;
        logic last;   // final bit of the message
    } emitBit;

    typedef enum logic [3:0] {
        stIdle, stMult, stDivHigh, stWaitHigh,
        stDivLow, stWaitLow, stScale, stPending,
        stFinal, stUpdate, stModelWait, stReqBits,
        stBitsAck, stDrain
    } encState;

endpackage

// File: logic/encoderCtrl.sv
// Encoder interval control
`timescale 1ns/1ns
`include "codec_consts.svh"

module encoderCtrl (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 start,
    input  codecPkg::symbolValue symbolIn,
    input  logic                 newBitsProvided,
    output logic                 idle,
    output logic                 newBitsRequested,
    output logic                 modelClear,
    output logic                 modelUpdate,
    output codecPkg::symbolValue curSymbol,
    input  codecPkg::symRange    range,
    input  logic                 modelReady,
    output logic                 divStart,
    output codecPkg::divRequest  request,
    input  logic                 divDone,
    input  codecPkg::codeValue   quotient,
    output codecPkg::emitBit     bitOut,
    input  logic                 packerStall
);

    codecPkg::encState     state;
    codecPkg::codeValue    low;
    codecPkg::codeValue    high;
    codecPkg::codeValue    width;
    codecPkg::codeValue    pending;     // bits owed by middle scaling
    logic                  pendBit;     // value of the owed bits
    logic                  finishing;   // end symbol is being flushed
    logic [`prodWidth-1:0] prodHigh;
    logic [`prodWidth-1:0] prodLow;
    logic                  leftHalf;
    logic                  rightHalf;
    logic                  middle;

    assign leftHalf  = high < `half;
    assign rightHalf = low > `half;
    assign middle    = low > `quarter && high < `threeQuarters;

    assign idle        = state == codecPkg::stIdle;
    assign modelClear  = state == codecPkg::stIdle && start;
    assign modelUpdate = state == codecPkg::stUpdate;
    assign divStart    = state == codecPkg::stDivHigh || state == codecPkg::stDivLow;

    assign request.dividend = (state == codecPkg::stDivLow) ? prodLow : prodHigh;
    assign request.divisor  = range.total;

    // bit offered to the packer in the current state
    always_comb begin
        bitOut = '0;
        case (state)
            codecPkg::stScale: begin
                bitOut.valid = (leftHalf || rightHalf) && !packerStall;
                bitOut.value = rightHalf;
            end
            codecPkg::stFinal: begin
                bitOut.valid = !packerStall;
                bitOut.value = low > `quarter;
            end
            codecPkg::stPending: begin
                bitOut.valid = !packerStall;
                bitOut.value = pendBit;
                bitOut.last  = finishing && pending == 1;
            end
            default: bitOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state            <= codecPkg::stIdle;
            newBitsRequested <= 1'b0;
        end else begin
            case (state)
                codecPkg::stIdle: begin
                    if (start) begin
                        curSymbol <= symbolIn;
                        low       <= '0;
                        high      <= `whole;
                        width     <= `whole;
                        pending   <= '0;
                        finishing <= 1'b0;
                        state     <= codecPkg::stMult;
                    end
                end
                codecPkg::stMult: begin
                    prodHigh <= `prodWidth'(width) * `prodWidth'(range.freqEnd);
                    prodLow  <= `prodWidth'(width) * `prodWidth'(range.freqBegin);
                    state    <= codecPkg::stDivHigh;
                end
                codecPkg::stDivHigh: state <= codecPkg::stWaitHigh;
                codecPkg::stWaitHigh: begin
                    if (divDone) begin
                        high  <= low + quotient;   // low is still the old bound here
                        state <= codecPkg::stDivLow;
                    end
                end
                codecPkg::stDivLow: state <= codecPkg::stWaitLow;
                codecPkg::stWaitLow: begin
                    if (divDone) begin
                        low   <= low + quotient;
                        state <= codecPkg::stScale;
                    end
                end
                codecPkg::stScale: begin
                    if (leftHalf || rightHalf) begin
                        if (!packerStall) begin
                            if (leftHalf) begin
                                low     <= low << 1;
                                high    <= high << 1;
                                pendBit <= 1'b1;
                            end else begin
                                low     <= (low - `half) << 1;
                                high    <= (high - `half) << 1;
                                pendBit <= 1'b0;
                            end
                            if (pending != 0) begin
                                state <= codecPkg::stPending;
                            end
                        end
                    end else if (middle) begin
                        low     <= (low - `quarter) << 1;
                        high    <= (high - `quarter) << 1;
                        pending <= pending + 1'b1;
                    end else if (curSymbol == `eofSymbol) begin
                        state <= codecPkg::stFinal;
                    end else begin
                        state <= codecPkg::stUpdate;
                    end
                end
                codecPkg::stPending: begin
                    if (!packerStall) begin
                        pending <= pending - 1'b1;
                        if (pending == 1) begin
                            state <= finishing ? codecPkg::stDrain : codecPkg::stScale;
                        end
                    end
                end
                codecPkg::stFinal: begin
                    if (!packerStall) begin
                        pending   <= pending + 1'b1;
                        pendBit   <= !(low > `quarter);
                        finishing <= 1'b1;
                        state     <= codecPkg::stPending;
                    end
                end
                codecPkg::stUpdate: state <= codecPkg::stModelWait;
                codecPkg::stModelWait: begin
                    if (modelReady) begin
                        newBitsRequested <= 1'b1;
                        width            <= high - low;
                        state            <= codecPkg::stReqBits;
                    end
                end
                codecPkg::stReqBits: begin
                    if (newBitsProvided) begin
                        curSymbol        <= symbolIn;
                        newBitsRequested <= 1'b0;
                        state            <= codecPkg::stBitsAck;
                    end
                end
                codecPkg::stBitsAck: begin
                    if (!newBitsProvided) begin
                        state <= codecPkg::stMult;
                    end
                end
                codecPkg::stDrain: begin
                    if (!packerStall) begin   // final word has been read
                        state <= codecPkg::stIdle;
                    end
                end
                default: state <= codecPkg::stIdle;
            endcase
        end
    end

endmodule

// File: logic/freqModel.sv
// Adaptive frequency model
`timescale 1ns/1ns
`include "codec_consts.svh"

module freqModel (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 modelClear,
    input  codecPkg::symbolValue curSymbol,
    input  logic                 modelUpdate,
    output codecPkg::symRange    range,
    output logic                 modelReady
);

    codecPkg::freqValue   countTab [`numSymbols];
    codecPkg::freqValue   beginTab [`numSymbols];
    codecPkg::freqValue   endTab [`numSymbols];
    codecPkg::freqValue   total;

    logic                 halvePhase;     // halve all counts this cycle
    logic                 rebuildPhase;   // walking the table
    logic                 incPhase;       // increment deferred past the rebuild
    codecPkg::symbolValue rebuildIdx;
    codecPkg::freqValue   runSum;         // cumulative count so far
    logic                 atLimit;
    logic                 lastIdx;
    logic                 incNow;

    assign modelReady = !(halvePhase || rebuildPhase || incPhase);
    assign atLimit    = total == codecPkg::freqValue'(`quarter - 1);
    assign lastIdx    = rebuildIdx == codecPkg::symbolValue'(`numSymbols - 1);
    assign incNow     = (modelUpdate && modelReady && !atLimit) || incPhase;

    assign range.freqBegin = beginTab[curSymbol];
    assign range.freqEnd   = endTab[curSymbol];
    assign range.total     = total;

    always_ff @(posedge clk) begin
        if (!rstn || modelClear) begin
            halvePhase   <= 1'b0;
            rebuildPhase <= 1'b0;
            incPhase     <= 1'b0;
        end else if (halvePhase) begin
            halvePhase   <= 1'b0;
            rebuildPhase <= 1'b1;
        end else if (rebuildPhase) begin
            if (lastIdx) begin
                rebuildPhase <= 1'b0;
                incPhase     <= 1'b1;
            end
        end else if (incPhase) begin
            incPhase <= 1'b0;
        end else if (modelUpdate && atLimit) begin
            halvePhase <= 1'b1;   // total hit the cap
        end
    end

    always_ff @(posedge clk) begin
        if (modelClear) begin
            for (int i = 0; i < `numSymbols; i++) begin
                countTab[i] <= codecPkg::freqValue'(1);
                beginTab[i] <= codecPkg::freqValue'(i);
                endTab[i]   <= codecPkg::freqValue'(i + 1);
            end
            total <= codecPkg::freqValue'(`numSymbols);
        end else if (halvePhase) begin
            for (int i = 0; i < `numSymbols; i++) begin
                if (countTab[i] > 1) begin   // a count of 1 keeps its slot
                    countTab[i] <= countTab[i] >> 1;
                end
            end
            rebuildIdx <= '0;
            runSum     <= '0;
        end else if (rebuildPhase) begin
            beginTab[rebuildIdx] <= runSum;
            endTab[rebuildIdx]   <= runSum + countTab[rebuildIdx];
            runSum               <= runSum + countTab[rebuildIdx];
            total                <= runSum + countTab[rebuildIdx];
            rebuildIdx           <= rebuildIdx + 1'b1;
        end else if (incNow) begin
            countTab[curSymbol] <= countTab[curSymbol] + 1'b1;
            total               <= total + 1'b1;
            for (int i = 0; i < `numSymbols; i++) begin
                if (i > curSymbol) begin
                    beginTab[i] <= beginTab[i] + 1'b1;
                end
                if (i >= curSymbol) begin
                    endTab[i] <= endTab[i] + 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/seqDivider.sv
// Restoring sequential divider
`timescale 1ns/1ns
`include "codec_consts.svh"

module seqDivider (
    input  logic                clk,
    input  logic                rstn,
    input  logic                divStart,
    input  codecPkg::divRequest request,
    output logic                divDone,
    output codecPkg::codeValue  quotient
);

    logic [`prodWidth-1:0] dvdReg;     // dividend bits leave at the top as quotient bits enter
    codecPkg::freqValue    divisorReg;
    codecPkg::freqValue    remReg;
    logic [`freqWidth:0]   remShift;
    logic [`freqWidth:0]   remTrial;
    logic                  fits;
    logic [4:0]            stepCnt;
    logic                  busy;

    assign remShift = {remReg, dvdReg[`prodWidth-1]};
    assign remTrial = remShift - {1'b0, divisorReg};
    assign fits     = !remTrial[`freqWidth];   // no borrow
    assign quotient = dvdReg[`codecPrecision-1:0];   // result is bounded by the width

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            stepCnt <= '0;
            divDone <= 1'b0;
        end else begin
            divDone <= busy && stepCnt == 5'd1;
            if (!busy && divStart) begin
                busy    <= 1'b1;
                stepCnt <= 5'(`prodWidth);   // one quotient bit per cycle
            end else if (busy) begin
                stepCnt <= stepCnt - 1'b1;
                if (stepCnt == 5'd1) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && divStart) begin
            dvdReg     <= request.dividend;
            divisorReg <= request.divisor;
            remReg     <= '0;
        end else if (busy) begin
            remReg <= fits ? remTrial[`freqWidth-1:0] : remShift[`freqWidth-1:0];
            dvdReg <= {dvdReg[`prodWidth-2:0], fits};
        end
    end

endmodule

// File: verif/arithEncoderTb.sv
// Arithmetic encoder testbench
`timescale 1ns/1ns
`include "codec_consts.svh"

module arithEncoderTb;

    localparam int randLenA   = 300;
    localparam int repLen     = 8000;
    localparam int randLenC   = 200;
    localparam int cycleLimit = (randLenA + repLen + randLenC + 3) * 400 + 2000;

    logic        clk;
    logic        rstn;
    logic        start;
    logic [8:0]  symbolIn;
    logic        newBitsProvided;
    logic        readSuccess;
    logic        idle;
    logic        newBitsRequested;
    logic        resultReady;
    logic [2:0]  validOutputBytes;
    logic [31:0] codeWord;

    integer      seed = 80285;
    int          errors = 0;
    int          wordsChecked = 0;
    int          cycleCount = 0;
    int          reqRises = 0;
    int          msg [$];
    bit          expBits [$];
    logic [31:0] gotWords [$];
    int          gotBytes [$];
    logic        prevReady = 1'b0;
    logic        prevReq = 1'b0;
    logic [31:0] prevWord;
    logic [2:0]  prevBytes;

    arithEncoder dut0 (.clk, .rstn, .start, .symbolIn, .newBitsProvided, .readSuccess, .idle,
        .newBitsRequested, .resultReady, .validOutputBytes, .codeWord);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the encoder did not finish within %0d cycles", cycleLimit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // inputs change and outputs are read 1 ns after the edge
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int pickDelay();
        return $unsigned($random(seed)) % 6;
    endfunction

    function automatic void appendBits(input bit value, input int count);
        repeat (count) expBits.push_back(value);
    endfunction

    // software model of the encoder, fills expBits from msg
    function automatic void referenceEncode();
        int count [`numSymbols];
        int total;
        int low;
        int high;
        int width;
        int pending;
        int fBegin;
        int sym;
        bit lastBit;
        for (int i = 0; i < `numSymbols; i++) begin
            count[i] = 1;
        end
        total   = `numSymbols;
        low     = 0;
        high    = `whole;
        width   = `whole;
        pending = 0;
        expBits.delete();
        foreach (msg[k]) begin
            sym    = msg[k];
            fBegin = 0;
            for (int i = 0; i < sym; i++) begin
                fBegin += count[i];
            end
            high = low + width * (fBegin + count[sym]) / total;   // both use the old low
            low  = low + width * fBegin / total;
            forever begin
                if (high < `half) begin
                    appendBits(1'b0, 1);
                    appendBits(1'b1, pending);
                    pending = 0;
                    low     = low * 2;
                    high    = high * 2;
                end else if (low > `half) begin
                    appendBits(1'b1, 1);
                    appendBits(1'b0, pending);
                    pending = 0;
                    low     = (low - `half) * 2;
                    high    = (high - `half) * 2;
                end else if (low > `quarter && high < `threeQuarters) begin
                    pending++;
                    low  = (low - `quarter) * 2;
                    high = (high - `quarter) * 2;
                end else begin
                    break;
                end
            end
            if (sym == `eofSymbol) begin
                pending++;
                lastBit = low > `quarter;
                appendBits(lastBit, 1);
                appendBits(!lastBit, pending);
            end else begin
                if (total == `quarter - 1) begin   // halve before counting
                    total = 0;
                    for (int i = 0; i < `numSymbols; i++) begin
                        if (count[i] > 1) begin
                            count[i] = count[i] / 2;
                        end
                        total += count[i];
                    end
                end
                count[sym]++;
                total++;
                width = high - low;
            end
        end
    endfunction

    // len bytes, random when fillByte is negative, then the end symbol
    task automatic buildMessage(input int len, input int fillByte);
        msg.delete();
        for (int k = 0; k < len; k++) begin
            msg.push_back(fillByte < 0 ? $unsigned($random(seed)) % 256 : fillByte);
        end
        msg.push_back(`eofSymbol);
    endtask

    task automatic checkStream();
        int          nWords;
        int          expBytes;
        logic [31:0] expWord;
        nWords = (expBits.size() + 31) / 32;
        assert (gotWords.size() == nWords) else begin
            errors++;
            $display("Error at %0t: %0d words received, expected %0d", $time,
                gotWords.size(), nWords);
        end
        for (int w = 0; w < nWords && w < gotWords.size(); w++) begin
            expWord = '0;
            for (int b = 0; b < 32 && w * 32 + b < expBits.size(); b++) begin
                expWord[b] = expBits[w * 32 + b];
            end
            expBytes = (w == nWords - 1) ? (expBits.size() - w * 32 + 7) / 8 : 4;
            assert (gotWords[w] === expWord) else begin
                errors++;
                $display("Error at %0t: word %0d is %h, expected %h", $time, w,
                    gotWords[w], expWord);
            end
            assert (gotBytes[w] == expBytes) else begin
                errors++;
                $display("Error at %0t: word %0d has %0d bytes, expected %0d", $time, w,
                    gotBytes[w], expBytes);
            end
            wordsChecked++;
        end
        assert (reqRises == msg.size() - 1) else begin
            errors++;
            $display("Error at %0t: %0d symbol requests, expected %0d", $time, reqRises,
                msg.size() - 1);
        end
    endtask

    task automatic encodeMessage();
        referenceEncode();
        gotWords.delete();
        gotBytes.delete();
        reqRises = 0;
        symbolIn = 9'(msg[0]);
        start    = 1'b1;
        nextCycle();
        start = 1'b0;
        for (int k = 1; k < msg.size(); k++) begin
            while (!newBitsRequested) nextCycle();
            repeat (pickDelay()) nextCycle();
            symbolIn        = 9'(msg[k]);
            newBitsProvided = 1'b1;
            nextCycle();
            while (newBitsRequested) nextCycle();
            repeat (pickDelay()) nextCycle();
            newBitsProvided = 1'b0;
        end
        while (!idle) nextCycle();   // final word has been read
        checkStream();
    endtask

    // word reader with random handshake delays
    initial begin
        forever begin
            nextCycle();
            if (resultReady === 1'b1) begin
                gotWords.push_back(codeWord);
                gotBytes.push_back(validOutputBytes);
                repeat (pickDelay()) nextCycle();
                readSuccess = 1'b1;
                while (resultReady) nextCycle();
                repeat (pickDelay()) nextCycle();
                readSuccess = 1'b0;
            end
        end
    end

    // output stability and request edges
    initial begin
        forever begin
            nextCycle();
            if (resultReady === 1'b1 && prevReady) begin
                assert (codeWord === prevWord && validOutputBytes === prevBytes) else begin
                    errors++;
                    $display("Error at %0t: output word changed while resultReady high",
                        $time);
                end
            end
            if (newBitsRequested === 1'b1 && !prevReq) begin
                reqRises++;
            end
            prevReady = resultReady === 1'b1;
            prevReq   = newBitsRequested === 1'b1;
            prevWord  = codeWord;
            prevBytes = validOutputBytes;
        end
    end

    initial begin
        clk             = 1'b0;
        rstn            = 1'b0;
        start           = 1'b0;
        symbolIn        = '0;
        newBitsProvided = 1'b0;
        readSuccess     = 1'b0;
        repeat (5) nextCycle();
        rstn = 1'b1;
        nextCycle();
        assert (idle === 1'b1 && resultReady === 1'b0 && newBitsRequested === 1'b0) else begin
            errors++;
            $display("Error at %0t: outputs not at their reset values", $time);
        end
        buildMessage(randLenA, -1);
        encodeMessage();
        buildMessage(repLen, 8'h41);   // long run crosses the halving limit
        encodeMessage();
        buildMessage(randLenC, -1);
        encodeMessage();
        $display("Closing: %0d words checked, %0d errors", wordsChecked, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
